// ==== hdl/sd_card_reg_pkg.sv ====
// card register contents with OCR, CID and CSD values, RCA step, ACMD41 count, register struct
`default_nettype none

package sd_card_reg_pkg;

   // high capacity host support, 2.7 to 3.6 V window, busy until power-up
   localparam logic [31:0] OCR_RESET      = 32'h40FF_8000;
   localparam int          OCR_POWERED_UP = 31;

   localparam logic [15:0] RCA_STEP           = 16'h1337;
   localparam logic [3:0]  ACMD41_READY_COUNT = 4'd3;

   // MID, OID, name, revision, serial, reserved, date, CRC with end bit
   localparam logic [127:0] CID_VALUE = {
      8'h02, 16'h4C4B, 40'h4C4E_4B43_4D, 8'h10, 32'h0000_2A17, 4'h0, 12'h0F3, 8'hFF
   };

   // version 2.0 layout, 512 byte blocks at 25 MHz, about 3.8 GB
   localparam logic [127:0] CSD_VALUE = {
      // structure, TAAC, NSAC, TRAN_SPEED
      2'b01, 6'h0, 8'h0E, 8'h00, 8'h32,
      // CCC, READ_BL_LEN, partial and misalign flags, DSR
      12'h5B5, 4'h9, 4'b0000, 6'h0,
      // C_SIZE, ERASE_BLK_EN, SECTOR_SIZE
      22'h00_1D5F, 1'b0, 1'b1, 7'h7F,
      // write protect group, R2W_FACTOR, WRITE_BL_LEN
      7'h00, 1'b0, 2'b00, 3'b010, 4'h9, 1'b0, 5'h0,
      // file format and protection bits, then CRC with end bit
      1'b0, 1'b0, 1'b0, 1'b0, 2'b00, 2'h0, 8'hFF
   };

   typedef struct packed {
      logic [31:0] status;
      logic [15:0] rca;
      logic [31:0] ocr;
   } card_regs_t;

endpackage

`default_nettype wire

// ==== hdl/sd_cmd_fsm.sv ====
// command decode and SD card state machine with RCA, OCR, status and error flags
`timescale 1ns/1ns
`default_nettype none

module sd_cmd_fsm
   import sd_proto_pkg::*;
   import sd_card_reg_pkg::*;
(
   input  wire logic        clk_50,
   input  wire logic        reset_s,
   input  wire phy_strobe_t strobe,
   input  wire phy_strobe_t strobe_prev,
   input  wire cmd_frame_t  cmd_frame,
   output cmd_result_t      result,
   output card_regs_t       regs,
   output logic             load,
   output logic             phy_resp_act,
   output card_state_t      link_card_state,
   output cmd_index_t       cmd_in_last,
   output logic             info_card_desel,
   output logic             err_host_is_spi,
   output logic             err_unhandled_cmd,
   output logic             err_cmd_crc
);

   typedef enum logic [2:0] {
      ST_RESET, ST_IDLE, ST_ACT, ST_RESP_0, ST_RESP_1, ST_RESP_2
   } fsm_state_t;

   fsm_state_t  state;
   cmd_frame_t  cmd_latch;
   card_state_t card_state_next;
   logic [3:0]  acmd41_count;
   logic        app_cmd;
   logic        act_rise;
   logic        done_rise;
   logic        rca_match;
   logic [31:0] status_clear;

   assign act_rise  = strobe.cmd_act & ~strobe_prev.cmd_act;
   assign done_rise = strobe.resp_done & ~strobe_prev.resp_done;
   assign rca_match = (cmd_latch.argument[31:16] == regs.rca);

   // framer captures in the same cycle that phy_resp_act is set
   assign load = (state == ST_RESP_1) && !(result.kind inside {RESP_NONE, RESP_BAD});

   // error bits are reported once
   // the clear-on-read set goes only after CMD13
   assign status_clear = (32'h1 << STAT_COM_CRC_ERROR) | (32'h1 << STAT_ILLEGAL_COMMAND)
      | ((cmd_latch.index == CMD13_SEND_STATUS) ? CLEAR_ON_READ_MASK : 32'h0)
      | ((app_cmd && cmd_latch.index != CMD55_APP_CMD) ? (32'h1 << STAT_APP_CMD) : 32'h0);

   always_ff @(posedge clk_50) begin
      // CMD0 comes back through ST_RESET
      if (!reset_s || state == ST_RESET) begin
         state             <= ST_IDLE;
         link_card_state   <= CARD_IDLE;
         regs.status       <= 32'h1 << STAT_READY_FOR_DATA;
         regs.rca          <= 16'h0;
         regs.ocr          <= OCR_RESET;
         acmd41_count      <= 4'd0;
         app_cmd           <= 1'b0;
         phy_resp_act      <= 1'b0;
         cmd_in_last       <= '0;
         info_card_desel   <= 1'b0;
         err_host_is_spi   <= 1'b0;
         err_unhandled_cmd <= 1'b0;
         err_cmd_crc       <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (act_rise) begin
                  if (strobe.cmd_crc_good) begin
                     cmd_latch    <= cmd_frame;
                     result.index <= cmd_frame.index;
                     cmd_in_last  <= cmd_frame.index;
                     state        <= ST_ACT;
                  end else begin
                     err_cmd_crc                     <= 1'b1;
                     regs.status[STAT_COM_CRC_ERROR] <= 1'b1;
                  end
               end
            end
            ST_ACT: begin
               state           <= ST_RESP_0;
               card_state_next <= link_card_state;
               // anything not matched below is illegal in this state
               result.kind     <= RESP_BAD;
               if (!app_cmd) begin
                  case (cmd_latch.index)
                     CMD0_GO_IDLE: begin
                        if (link_card_state != CARD_INA)
                           state <= ST_RESET;
                     end
                     CMD1_SEND_OP_COND: err_host_is_spi <= 1'b1;
                     CMD2_ALL_SEND_CID: begin
                        if (link_card_state == CARD_READY) begin
                           result.kind     <= RESP_R2;
                           card_state_next <= CARD_IDENT;
                        end
                     end
                     CMD3_SEND_REL_ADDR: begin
                        if (link_card_state inside {CARD_IDENT, CARD_STBY}) begin
                           regs.rca        <= regs.rca + RCA_STEP;
                           result.kind     <= RESP_R6;
                           card_state_next <= CARD_STBY;
                        end
                     end
                     CMD7_SELECT_CARD: begin
                        if (!rca_match) begin
                           // another card was selected
                           result.kind     <= RESP_NONE;
                           info_card_desel <= 1'b1;
                           if (link_card_state == CARD_TRAN)
                              card_state_next <= CARD_STBY;
                        end else if (link_card_state == CARD_STBY) begin
                           result.kind     <= RESP_R1B;
                           card_state_next <= CARD_TRAN;
                        end
                     end
                     CMD8_SEND_IF_COND: begin
                        if (link_card_state == CARD_IDLE) begin
                           if (cmd_latch.argument[11:8] == 4'b0001) begin
                              result.kind    <= RESP_R7;
                              result.r7_echo <= cmd_latch.argument[11:0];
                           end else begin
                              result.kind <= RESP_NONE;
                           end
                        end
                     end
                     CMD9_SEND_CSD, CMD10_SEND_CID: begin
                        if (!rca_match)
                           result.kind <= RESP_NONE;
                        else if (link_card_state == CARD_STBY)
                           result.kind <= RESP_R2;
                     end
                     CMD13_SEND_STATUS: begin
                        if (!rca_match)
                           result.kind <= RESP_NONE;
                        else if (link_card_state inside {[CARD_STBY:CARD_DIS]})
                           result.kind <= RESP_R1;
                     end
                     CMD15_GO_INACTIVE: begin
                        result.kind <= RESP_NONE;
                        if (rca_match && link_card_state inside {[CARD_STBY:CARD_DIS]})
                           card_state_next <= CARD_INA;
                     end
                     CMD55_APP_CMD: begin
                        if (!rca_match) begin
                           result.kind <= RESP_NONE;
                        end else if (link_card_state inside {CARD_IDLE, [CARD_STBY:CARD_DIS]}) begin
                           result.kind               <= RESP_R1;
                           app_cmd                   <= 1'b1;
                           regs.status[STAT_APP_CMD] <= 1'b1;
                        end
                     end
                     default: err_unhandled_cmd <= 1'b1;
                  endcase
               end else begin
                  case (cmd_latch.index)
                     ACMD41_SEND_OP_COND: begin
                        if (link_card_state == CARD_IDLE) begin
                           result.kind  <= RESP_R3;
                           acmd41_count <= acmd41_count + 4'd1;
                           // an empty window is a query, and no HCS means never ready
                           if (cmd_latch.argument[23:0] != 24'h0 && cmd_latch.argument[30] &&
                               acmd41_count >= ACMD41_READY_COUNT) begin
                              regs.ocr[OCR_POWERED_UP] <= 1'b1;
                              card_state_next          <= CARD_READY;
                           end
                        end
                     end
                     default: begin
                        // unknown ACMD is decoded again as a plain command
                        app_cmd <= 1'b0;
                        state   <= ST_ACT;
                     end
                  endcase
               end
            end
            ST_RESP_0: begin
               regs.status[STAT_STATE_MSB:STAT_STATE_LSB] <= link_card_state;
               state <= ST_RESP_1;
            end
            ST_RESP_1: begin
               case (result.kind)
                  RESP_NONE: begin
                     link_card_state <= card_state_next;
                     state           <= ST_IDLE;
                  end
                  RESP_BAD: begin
                     regs.status[STAT_ILLEGAL_COMMAND] <= 1'b1;
                     state                             <= ST_IDLE;
                  end
                  default: begin
                     phy_resp_act <= 1'b1;
                     state        <= ST_RESP_2;
                  end
               endcase
            end
            ST_RESP_2: begin
               // hold the response until the PHY reports it sent
               if (done_rise) begin
                  regs.status     <= regs.status & ~status_clear;
                  if (cmd_latch.index != CMD55_APP_CMD)
                     app_cmd <= 1'b0;
                  phy_resp_act    <= 1'b0;
                  link_card_state <= card_state_next;
                  state           <= ST_IDLE;
               end
            end
            default: state <= ST_RESET;
         endcase
      end
   end

   a_resp_act_rise: assert property (@(posedge clk_50) disable iff (!reset_s)
      $rose(phy_resp_act) |-> state == ST_RESP_2 && $past(load))
      else $error("phy_resp_act rose outside RESP_2 or without a loaded response");

   a_load_kind: assert property (@(posedge clk_50) disable iff (!reset_s)
      load |=> phy_resp_act)
      else $error("load raised without a response to send");

endmodule

`default_nettype wire

// ==== hdl/sd_link.sv ====
// SD link top level with PHY synchronizers, command FSM and response framer
`timescale 1ns/1ns
`default_nettype none

module sd_link
   import sd_proto_pkg::*;
   import sd_card_reg_pkg::*;
(
   input  wire logic                  clk_50,
   input  wire logic                  reset_s,
   input  wire cmd_frame_t            phy_cmd_in,
   input  wire logic                  phy_cmd_in_act,
   input  wire logic                  phy_cmd_in_crc_good,
   input  wire logic                  phy_resp_done,
   output wire card_state_t           link_card_state,
   output wire logic [RESP_WIDTH-1:0] phy_resp_out,
   output wire resp_kind_t            phy_resp_type,
   output wire logic                  phy_resp_act,
   output wire cmd_index_t            cmd_in_last,
   output wire logic                  info_card_desel,
   output wire logic                  err_host_is_spi,
   output wire logic                  err_unhandled_cmd,
   output wire logic                  err_cmd_crc
);

   wire phy_strobe_t strobe_in;
   wire phy_strobe_t strobe_s;
   wire phy_strobe_t strobe_r;
   wire cmd_frame_t  cmd_s;
   wire cmd_result_t result;
   wire card_regs_t  regs;
   wire logic        load;

   assign strobe_in = '{
      cmd_act:      phy_cmd_in_act,
      cmd_crc_good: phy_cmd_in_crc_good,
      resp_done:    phy_resp_done
   };

   sd_synch #(.payload_t(phy_strobe_t)) u_synch_strobe (
      .clk_50 (clk_50),
      .d      (strobe_in),
      .q      (strobe_s),
      .q_prev (strobe_r)
   );

   // frame is steady before act rises, so no edge copy is needed
   sd_synch #(.payload_t(cmd_frame_t)) u_synch_cmd (
      .clk_50 (clk_50),
      .d      (phy_cmd_in),
      .q      (cmd_s),
      .q_prev ()
   );

   sd_cmd_fsm u_cmd_fsm (
      .clk_50            (clk_50),
      .reset_s           (reset_s),
      .strobe            (strobe_s),
      .strobe_prev       (strobe_r),
      .cmd_frame         (cmd_s),
      .result            (result),
      .regs              (regs),
      .load              (load),
      .phy_resp_act      (phy_resp_act),
      .link_card_state   (link_card_state),
      .cmd_in_last       (cmd_in_last),
      .info_card_desel   (info_card_desel),
      .err_host_is_spi   (err_host_is_spi),
      .err_unhandled_cmd (err_unhandled_cmd),
      .err_cmd_crc       (err_cmd_crc)
   );

   sd_resp_frame u_resp_frame (
      .clk_50        (clk_50),
      .load          (load),
      .result        (result),
      .regs          (regs),
      .phy_resp_out  (phy_resp_out),
      .phy_resp_type (phy_resp_type)
   );

endmodule

`default_nettype wire

// ==== hdl/sd_proto_pkg.sv ====
// SD protocol definitions with command codes, card states, response kinds, status bits, PHY structs
`default_nettype none

package sd_proto_pkg;

   localparam int RESP_WIDTH = 136;

   typedef logic [5:0] cmd_index_t;

   // commands handled by the link
   localparam cmd_index_t CMD0_GO_IDLE        = 6'd0;
   localparam cmd_index_t CMD1_SEND_OP_COND   = 6'd1;
   localparam cmd_index_t CMD2_ALL_SEND_CID   = 6'd2;
   localparam cmd_index_t CMD3_SEND_REL_ADDR  = 6'd3;
   localparam cmd_index_t CMD7_SELECT_CARD    = 6'd7;
   localparam cmd_index_t CMD8_SEND_IF_COND   = 6'd8;
   localparam cmd_index_t CMD9_SEND_CSD       = 6'd9;
   localparam cmd_index_t CMD10_SEND_CID      = 6'd10;
   localparam cmd_index_t CMD13_SEND_STATUS   = 6'd13;
   localparam cmd_index_t CMD15_GO_INACTIVE   = 6'd15;
   localparam cmd_index_t CMD55_APP_CMD       = 6'd55;
   localparam cmd_index_t ACMD41_SEND_OP_COND = 6'd41;

   // numbered as in the CURRENT_STATE status field where INA has no code
   typedef enum logic [3:0] {
      CARD_IDLE  = 4'd0,
      CARD_READY = 4'd1,
      CARD_IDENT = 4'd2,
      CARD_STBY  = 4'd3,
      CARD_TRAN  = 4'd4,
      CARD_DATA  = 4'd5,
      CARD_RCV   = 4'd6,
      CARD_PRG   = 4'd7,
      CARD_DIS   = 4'd8,
      CARD_INA   = 4'd9
   } card_state_t;

   typedef enum logic [3:0] {
      RESP_NONE = 4'd0,
      RESP_BAD  = 4'd1,
      RESP_R1   = 4'd2,
      RESP_R1B  = 4'd3,
      RESP_R2   = 4'd4,
      RESP_R3   = 4'd5,
      RESP_R6   = 4'd6,
      RESP_R7   = 4'd7
   } resp_kind_t;

   // card status bit positions
   localparam int STAT_COM_CRC_ERROR   = 23;
   localparam int STAT_ILLEGAL_COMMAND = 22;
   localparam int STAT_STATE_MSB       = 12;
   localparam int STAT_STATE_LSB       = 9;
   localparam int STAT_READY_FOR_DATA  = 8;
   localparam int STAT_APP_CMD         = 5;

   // bits 31..26, 24, 21, 20, 16, 15, 13, 5 and 3
   localparam logic [31:0] CLEAR_ON_READ_MASK = 32'hFD31_A028;

   typedef struct packed {
      logic [1:0]  start;
      cmd_index_t  index;
      logic [31:0] argument;
      logic [6:0]  crc;
      logic        end_bit;
   } cmd_frame_t;

   typedef struct packed {
      logic cmd_act;
      logic cmd_crc_good;
      logic resp_done;
   } phy_strobe_t;

   typedef struct packed {
      resp_kind_t  kind;
      cmd_index_t  index;
      logic [11:0] r7_echo;
   } cmd_result_t;

endpackage

`default_nettype wire

// ==== hdl/sd_resp_frame.sv ====
// response framer that builds the 136-bit response and its kind when load is high
`timescale 1ns/1ns
`default_nettype none

module sd_resp_frame
   import sd_proto_pkg::*;
   import sd_card_reg_pkg::*;
(
   input  wire logic             clk_50,
   input  wire logic             load,
   input  wire cmd_result_t      result,
   input  wire card_regs_t       regs,
   output logic [RESP_WIDTH-1:0] phy_resp_out,
   output resp_kind_t            phy_resp_type
);

   logic [15:0] status_short;

   // R6 carries status bits 23, 22, 19 and 12..0
   assign status_short = {regs.status[23:22], regs.status[19], regs.status[12:0]};

   always_ff @(posedge clk_50) begin
      if (load) begin
         phy_resp_type <= result.kind;
         case (result.kind)
            RESP_R1, RESP_R1B: begin
               phy_resp_out <= {2'b00, result.index, regs.status, 8'h01, 88'h0};
            end
            RESP_R2: begin
               // CID and CSD hold their own CRC and only the end bit is forced
               if (result.index == CMD9_SEND_CSD)
                  phy_resp_out <= {2'b00, 6'b111111, CSD_VALUE[127:1], 1'b1};
               else
                  phy_resp_out <= {2'b00, 6'b111111, CID_VALUE[127:1], 1'b1};
            end
            RESP_R3: begin
               phy_resp_out <= {2'b00, 6'b111111, regs.ocr, 8'hFF, 88'h0};
            end
            RESP_R6: begin
               phy_resp_out <= {2'b00, result.index, regs.rca, status_short, 8'h01, 88'h0};
            end
            RESP_R7: begin
               phy_resp_out <= {2'b00, result.index, 20'h0, result.r7_echo, 8'h01, 88'h0};
            end
            default: phy_resp_out <= '0;
         endcase
      end
   end

   a_type_after_load: assert property (@(posedge clk_50)
      load |=> !(phy_resp_type inside {RESP_NONE, RESP_BAD}))
      else $error("response kind after load is not a sendable response");

endmodule

`default_nettype wire

// ==== hdl/sd_synch.sv ====
// three-stage synchronizer for any payload, with one more stage for edge detection
`timescale 1ns/1ns
`default_nettype none

module sd_synch
   import sd_proto_pkg::*;
#(
   parameter type payload_t = phy_strobe_t
) (
   input  wire logic     clk_50,
   input  wire payload_t d,
   output payload_t      q,
   output payload_t      q_prev
);

   payload_t stage_1;
   payload_t stage_2;
   payload_t stage_3;
   payload_t stage_4;

   always_ff @(posedge clk_50) begin
      stage_1 <= d;
      stage_2 <= stage_1;
      stage_3 <= stage_2;
      stage_4 <= stage_3;
   end

   // q lags d by three cycles, q_prev by four
   assign q      = stage_3;
   assign q_prev = stage_4;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the SD link testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sd_link -f vlog.f \
   || { echo "build failed"; exit 1; }

./obj_dir/Vtb_sd_link | tee /dev/stderr | grep -qx "No errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== testbench/tb_sd_link.sv ====
// sd_link testbench with clock, reset, PHY model, LFSR, command sequence and checks
`timescale 1ns/1ns
`default_nettype none

module tb_sd_link
   import sd_proto_pkg::*;
   import sd_card_reg_pkg::*;
();

   // 46 commands of 17 to 28 cycles each plus margin
   localparam int TIMEOUT_CYCLES = 1500;
   localparam logic [31:0] RCA_ARG     = {RCA_STEP, 16'h0};
   localparam logic [31:0] APP_BIT     = 32'h1 << STAT_APP_CMD;
   localparam logic [31:0] ILL_BIT     = 32'h1 << STAT_ILLEGAL_COMMAND;
   localparam logic [31:0] STATE_FIELD = 32'hF << STAT_STATE_LSB;

   logic                  clk_50;
   logic                  reset_s;
   cmd_frame_t            phy_cmd_in;
   logic                  phy_cmd_in_act;
   logic                  phy_cmd_in_crc_good;
   logic                  phy_resp_done;
   card_state_t           link_card_state;
   logic [RESP_WIDTH-1:0] phy_resp_out;
   resp_kind_t            phy_resp_type;
   logic                  phy_resp_act;
   cmd_index_t            cmd_in_last;
   logic                  info_card_desel;
   logic                  err_host_is_spi;
   logic                  err_unhandled_cmd;
   logic                  err_cmd_crc;

   // expectation for the command in flight
   logic [RESP_WIDTH-1:0] exp_out;
   logic [RESP_WIDTH-1:0] exp_mask;
   resp_kind_t            exp_type;
   logic                  expect_resp;
   logic                  crc_ok;
   string                 test_name;
   string                 cur_step;
   logic [31:0]           lfsr = 32'ha9e5;
   int                    err_count = 0;
   int                    test_count = 0;
   int                    errs_at_start = 0;
   int                    cycle_count = 0;

   sd_link u_dut (
      .clk_50              (clk_50),
      .reset_s             (reset_s),
      .phy_cmd_in          (phy_cmd_in),
      .phy_cmd_in_act      (phy_cmd_in_act),
      .phy_cmd_in_crc_good (phy_cmd_in_crc_good),
      .phy_resp_done       (phy_resp_done),
      .link_card_state     (link_card_state),
      .phy_resp_out        (phy_resp_out),
      .phy_resp_type       (phy_resp_type),
      .phy_resp_act        (phy_resp_act),
      .cmd_in_last         (cmd_in_last),
      .info_card_desel     (info_card_desel),
      .err_host_is_spi     (err_host_is_spi),
      .err_unhandled_cmd   (err_unhandled_cmd),
      .err_cmd_crc         (err_cmd_crc)
   );

   initial begin
      clk_50 = 1'b0;
      forever #5 clk_50 = ~clk_50;
   end

   always @(posedge clk_50) cycle_count <= cycle_count + 1;

   initial begin
      wait (cycle_count == TIMEOUT_CYCLES);
      $display("timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
   end

   a_resp_expected: assert property (@(posedge clk_50) disable iff (!reset_s)
      $rose(phy_resp_act) |-> expect_resp)
      else begin
         err_count++;
         $display("%s %s: a response was sent where none was expected", test_name, cur_step);
      end

   a_resp_type: assert property (@(posedge clk_50) disable iff (!reset_s)
      $rose(phy_resp_act) |-> phy_resp_type == exp_type)
      else begin
         err_count++;
         $display("FAIL %s %s type expected %0d actual %0d",
                  test_name, cur_step, exp_type, phy_resp_type);
      end

   a_resp_out: assert property (@(posedge clk_50) disable iff (!reset_s)
      $rose(phy_resp_act) |-> (phy_resp_out & exp_mask) == exp_out)
      else begin
         err_count++;
         $display("FAIL %s %s frame expected %h actual %h",
                  test_name, cur_step, exp_out, phy_resp_out & exp_mask);
      end

   // 48-bit style responses with start, index, 32-bit body, CRC and end marker
   function automatic logic [RESP_WIDTH-1:0] short_resp(input cmd_index_t idx,
                                                       input logic [31:0] body);
      return {2'b00, idx, body, 8'h01, 88'h0};
   endfunction

   function automatic logic [RESP_WIDTH-1:0] short_mask(input logic [31:0] body_mask);
      return {8'hFF, body_mask, {96{1'b1}}};
   endfunction

   function automatic logic [RESP_WIDTH-1:0] long_resp(input logic [127:0] card_reg);
      return {2'b00, 6'h3F, card_reg[127:1], 1'b1};
   endfunction

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act) else begin
         err_count++;
         $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk_50);
      reset_s = 1'b0;
      repeat (4) @(negedge clk_50);
      reset_s = 1'b1;
   endtask

   // flags low, no response pending and the card in IDLE
   task automatic check_reset_state();
      check_value("phy_resp_act after reset", 32'h0, 32'(phy_resp_act));
      check_value("flags after reset", 32'h0,
                  32'({info_card_desel, err_host_is_spi, err_unhandled_cmd, err_cmd_crc}));
      check_value("state after reset", 32'(CARD_IDLE), 32'(link_card_state));
   endtask

   task automatic send_cmd(input string step, input cmd_index_t idx, input logic [31:0] arg,
                           input resp_kind_t kind, input logic [RESP_WIDTH-1:0] out,
                           input logic [RESP_WIDTH-1:0] mask);
      int wait_cycles;
      cur_step    = step;
      exp_type    = kind;
      exp_mask    = mask;
      exp_out     = out & mask;
      expect_resp = !(kind inside {RESP_NONE, RESP_BAD});
      @(negedge clk_50);
      phy_cmd_in          = '{start: 2'b01, index: idx, argument: arg, crc: 7'h0, end_bit: 1'b1};
      phy_cmd_in_crc_good = crc_ok;
      @(negedge clk_50);
      phy_cmd_in_act = 1'b1;
      wait_cycles = 0;
      while (!phy_resp_act && wait_cycles < 20) begin
         @(negedge clk_50);
         wait_cycles++;
      end
      if (expect_resp) begin
         assert (phy_resp_act) else begin
            err_count++;
            $display("%s %s: no response within 20 cycles", test_name, step);
         end
      end
      // PHY reports the response sent
      phy_resp_done = phy_resp_act;
      repeat (2) @(negedge clk_50);
      phy_cmd_in_act = 1'b0;
      phy_resp_done  = 1'b0;
      wait_cycles = 0;
      while (phy_resp_act && wait_cycles < 8) begin
         @(negedge clk_50);
         wait_cycles++;
      end
      assert (!phy_resp_act) else begin
         err_count++;
         $display("%s %s: response was not released after done", test_name, step);
      end
      repeat (4) @(negedge clk_50);
   endtask

   // CMD55 and ACMD41 until the card reports power-up on the fourth round
   task automatic power_up();
      logic [31:0] ocr;
      for (int round = 0; round < 4; round++) begin
         ocr = (round == 3) ? (OCR_RESET | (32'h1 << OCR_POWERED_UP)) : OCR_RESET;
         send_cmd("CMD55", CMD55_APP_CMD, 32'h0, RESP_R1,
                  short_resp(CMD55_APP_CMD, APP_BIT), short_mask(APP_BIT));
         send_cmd("ACMD41", ACMD41_SEND_OP_COND, 32'h40FF_8000, RESP_R3,
                  {2'b00, 6'h3F, ocr, 8'hFF, 88'h0}, '1);
      end
      check_value("state after ACMD41", 32'(CARD_READY), 32'(link_card_state));
   endtask

   task automatic identify();
      send_cmd("CMD2", CMD2_ALL_SEND_CID, 32'h0, RESP_R2, long_resp(CID_VALUE), '1);
      check_value("state after CMD2", 32'(CARD_IDENT), 32'(link_card_state));
      send_cmd("CMD3", CMD3_SEND_REL_ADDR, 32'h0, RESP_R6,
               short_resp(CMD3_SEND_REL_ADDR, RCA_ARG), short_mask({16'hFFFF, 16'h0}));
      check_value("state after CMD3", 32'(CARD_STBY), 32'(link_card_state));
   endtask

   task automatic begin_test(input string name);
      test_name     = name;
      errs_at_start = err_count;
   endtask

   task automatic end_test();
      test_count++;
      $display("test %s finished with %0d errors", test_name, err_count - errs_at_start);
   endtask

   initial begin
      logic [7:0] pattern;
      phy_cmd_in          = '0;
      phy_cmd_in_act      = 1'b0;
      phy_cmd_in_crc_good = 1'b0;
      phy_resp_done       = 1'b0;
      reset_s             = 1'b0;
      crc_ok              = 1'b1;
      expect_resp         = 1'b0;
      exp_type            = RESP_NONE;
      exp_out             = '0;
      exp_mask            = '0;
      pattern             = 8'h0;
      test_name           = "reset";
      cur_step            = "";
      begin_test("reset");
      apply_reset();
      check_reset_state();
      end_test();

      begin_test("power_up");
      for (int i = 0; i < 8; i++) begin
         lfsr    = lfsr_step(lfsr);
         pattern = {pattern[6:0], lfsr[0]};
      end
      send_cmd("CMD8", CMD8_SEND_IF_COND, {20'h0, 4'h1, pattern}, RESP_R7,
               short_resp(CMD8_SEND_IF_COND, {20'h0, 4'h1, pattern}), '1);
      power_up();
      end_test();

      begin_test("identification");
      identify();
      send_cmd("CMD9", CMD9_SEND_CSD, RCA_ARG, RESP_R2, long_resp(CSD_VALUE), '1);
      send_cmd("CMD10", CMD10_SEND_CID, RCA_ARG, RESP_R2, long_resp(CID_VALUE), '1);
      end_test();

      begin_test("selection");
      send_cmd("CMD7", CMD7_SELECT_CARD, RCA_ARG, RESP_R1B,
               short_resp(CMD7_SELECT_CARD, 32'(CARD_STBY) << STAT_STATE_LSB),
               short_mask(STATE_FIELD));
      check_value("state after CMD7", 32'(CARD_TRAN), 32'(link_card_state));
      // CSD is not readable in TRAN
      send_cmd("CMD9 in TRAN", CMD9_SEND_CSD, RCA_ARG, RESP_BAD, '0, '0);
      send_cmd("CMD13 first", CMD13_SEND_STATUS, RCA_ARG, RESP_R1,
               short_resp(CMD13_SEND_STATUS, ILL_BIT | (32'(CARD_TRAN) << STAT_STATE_LSB)),
               short_mask(ILL_BIT | STATE_FIELD));
      send_cmd("CMD13 second", CMD13_SEND_STATUS, RCA_ARG, RESP_R1,
               short_resp(CMD13_SEND_STATUS, 32'(CARD_TRAN) << STAT_STATE_LSB),
               short_mask(ILL_BIT | STATE_FIELD));
      send_cmd("CMD7 other card", CMD7_SELECT_CARD, 32'h0001_0000, RESP_NONE, '0, '0);
      check_value("info_card_desel", 32'h1, 32'(info_card_desel));
      check_value("state after deselect", 32'(CARD_STBY), 32'(link_card_state));
      end_test();

      begin_test("errors");
      crc_ok = 1'b0;
      send_cmd("bad CRC", CMD13_SEND_STATUS, RCA_ARG, RESP_NONE, '0, '0);
      crc_ok = 1'b1;
      check_value("err_cmd_crc", 32'h1, 32'(err_cmd_crc));
      check_value("cmd_in_last after bad CRC", 32'(CMD7_SELECT_CARD), 32'(cmd_in_last));
      send_cmd("CMD1", CMD1_SEND_OP_COND, 32'h0, RESP_BAD, '0, '0);
      check_value("err_host_is_spi", 32'h1, 32'(err_host_is_spi));
      check_value("err_unhandled_cmd after CMD1", 32'h0, 32'(err_unhandled_cmd));
      send_cmd("CMD20", 6'd20, 32'h0, RESP_BAD, '0, '0);
      check_value("err_unhandled_cmd", 32'h1, 32'(err_unhandled_cmd));
      check_value("cmd_in_last", 32'd20, 32'(cmd_in_last));
      end_test();

      begin_test("app_retry_reset");
      send_cmd("CMD55", CMD55_APP_CMD, RCA_ARG, RESP_R1,
               short_resp(CMD55_APP_CMD, APP_BIT), short_mask(APP_BIT));
      // unknown ACMD falls back to plain CMD13
      send_cmd("ACMD13", CMD13_SEND_STATUS, RCA_ARG, RESP_R1,
               short_resp(CMD13_SEND_STATUS, APP_BIT | (32'(CARD_STBY) << STAT_STATE_LSB)),
               short_mask(APP_BIT | STATE_FIELD));
      send_cmd("CMD15", CMD15_GO_INACTIVE, RCA_ARG, RESP_NONE, '0, '0);
      check_value("state after CMD15", 32'(CARD_INA), 32'(link_card_state));
      send_cmd("CMD0 in INA", CMD0_GO_IDLE, 32'h0, RESP_BAD, '0, '0);
      check_value("state after CMD0 in INA", 32'(CARD_INA), 32'(link_card_state));
      apply_reset();
      check_reset_state();
      power_up();
      identify();
      send_cmd("CMD0", CMD0_GO_IDLE, 32'h0, RESP_BAD, '0, '0);
      check_value("state after CMD0", 32'(CARD_IDLE), 32'(link_card_state));
      power_up();
      identify();
      end_test();

      $display("tests run: %0d, errors: %0d", test_count, err_count);
      if (err_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/sd_proto_pkg.sv
hdl/sd_card_reg_pkg.sv
hdl/sd_synch.sv
hdl/sd_cmd_fsm.sv
hdl/sd_resp_frame.sv
hdl/sd_link.sv
testbench/tb_sd_link.sv
